//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ising_core
FILELIST  = ising_core.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) include/ising_cfg.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_clock_gen.sv
/* Clock and reset source of the testbench. Reset is held low for a fixed
   number of cycles and released just after a rising edge. */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/tb_ising_core.sv
/* Testbench of the Ising core. Loads couplings and spins over the register bus,
   runs the engine and checks every readback against a software energy model. */
`timescale 1ns/1ps
`default_nettype none

`include "ising_cfg.svh"

module tb_ising_core;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 40;
    // Wide margin over the expected length of all tests
    localparam int MAX_CYCLES  = NUM_TESTS * TEST_CYCLES * 8 + 80;

    wire                      clk;
    wire                      rst_n;
    logic [`ISING_ADDR_W-1:0] reg_addr;
    ising_pkg::reg_data_t     reg_wdata;
    logic                     reg_we;
    ising_pkg::reg_data_t     reg_rdata;

    // Read check request for the assertion at the next edge
    logic                     chk_en;
    ising_pkg::reg_data_t     chk_exp;

    ising_pkg::j_row_t        j_model [`ISING_NUM_SPIN];
    ising_pkg::spin_vec_t     spins;
    int                       seed;
    int                       exp_energy;
    int                       exp_unstable;
    int                       n_checks;
    int                       n_errors;
    int                       test_checks;
    int                       test_errors;
    int                       cycle;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) i_clock_gen (
        .clk_o   (clk  ),
        .rst_n_o (rst_n)
    );

    ising_core_top i_ising_core_top (
        .clk_i       (clk      ),
        .rst_n_i     (rst_n    ),
        .reg_addr_i  (reg_addr ),
        .reg_wdata_i (reg_wdata),
        .reg_we_i    (reg_we   ),
        .reg_rdata_o (reg_rdata)
    );

    a_read_value: assert property (
        @(posedge clk) disable iff (!rst_n)
        chk_en |-> (reg_rdata == chk_exp)
    ) else begin
        n_errors++;
        $display("ERROR at %0t: register %0d read 0x%h, expected 0x%h",
                 $time, reg_addr, $sampled(reg_rdata), chk_exp);
    end

    //////////////////////////////////////////////////////////////////////
    // Bus tasks enter and leave 1 ns after a rising edge
    task automatic write_reg(input logic [`ISING_ADDR_W-1:0] addr,
                             input ising_pkg::reg_data_t data);
        reg_addr  = addr;
        reg_wdata = data;
        reg_we    = 1'b1;
        @(posedge clk);
        #1;
        reg_we    = 1'b0;
    endtask

    task automatic check_reg(input logic [`ISING_ADDR_W-1:0] addr,
                             input ising_pkg::reg_data_t exp);
        reg_addr = addr;
        chk_exp  = exp;
        chk_en   = 1'b1;
        n_checks++;
        @(posedge clk);
        #1;
        chk_en   = 1'b0;
    endtask

    // STATUS is polled at the falling edge
    task automatic wait_idle(input logic level);
        reg_addr = `ISING_REG_STATUS;
        @(negedge clk);
        while (reg_rdata[0] != level) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Energy model with s as +1 for a set bit and -1 otherwise
    function automatic void model_results(input ising_pkg::spin_vec_t s_vec,
                                          output int energy, output int unstable);
        int s_i;
        int s_j;
        int coup;
        int field;
        energy   = 0;
        unstable = 0;
        for (int i = 0; i < `ISING_NUM_SPIN; i++) begin
            s_i   = s_vec[i] ? 1 : -1;
            field = 0;
            for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
                s_j   = s_vec[j] ? 1 : -1;
                coup  = int'($signed(j_model[i][j*`ISING_BIT_J +: `ISING_BIT_J]));
                field = field + coup * s_j;
            end
            energy = energy - s_i * field;
            if (s_i * field < 0) begin
                unstable++;
            end
        end
    endfunction

    task automatic load_couplings;
        write_reg(`ISING_REG_CTRL, 32'h4);
        for (int r = 0; r < `ISING_NUM_SPIN; r++) begin
            j_model[r] = $random(seed);
            write_reg(`ISING_REG_J_ADDR, ising_pkg::reg_data_t'(r));
            write_reg(`ISING_REG_J_DATA, j_model[r]);
        end
        write_reg(`ISING_REG_CTRL, 32'h0);
    endtask

    task automatic run_and_check(input ising_pkg::spin_vec_t s_vec);
        write_reg(`ISING_REG_SPIN, ising_pkg::reg_data_t'(s_vec));
        write_reg(`ISING_REG_CTRL, 32'h1);
        wait_idle(1'b0);
        wait_idle(1'b1);
        model_results(s_vec, exp_energy, exp_unstable);
        check_reg(`ISING_REG_STATUS, 32'h3);
        check_reg(`ISING_REG_ENERGY, ising_pkg::reg_data_t'(exp_energy));
        check_reg(`ISING_REG_UNSTABLE, ising_pkg::reg_data_t'(exp_unstable));
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name,
                 n_checks - test_checks, n_errors - test_errors);
        test_checks = n_checks;
        test_errors = n_errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    initial begin
        cycle = 0;
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout: tests still running after %0d clock cycles", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        reg_addr     = '0;
        reg_wdata    = '0;
        reg_we       = 1'b0;
        chk_en       = 1'b0;
        chk_exp      = '0;
        spins        = '0;
        seed         = 44359;
        exp_energy   = 0;
        exp_unstable = 0;
        n_checks     = 0;
        n_errors     = 0;
        test_checks  = 0;
        test_errors  = 0;
        @(posedge rst_n);
        @(posedge clk);
        #1;

        check_reg(`ISING_REG_STATUS, 32'h1);
        check_reg(`ISING_REG_ENERGY, 32'h0);
        check_reg(`ISING_REG_UNSTABLE, 32'h0);
        finish_test("test 1 after reset");

        load_couplings();
        spins = ising_pkg::spin_vec_t'($random(seed));
        run_and_check(spins);
        finish_test("test 2 random couplings");

        repeat (5) begin
            spins = ising_pkg::spin_vec_t'($random(seed));
            run_and_check(spins);
        end
        finish_test("test 3 new spin vectors");

        // Memory and model must both keep the old rows
        write_reg(`ISING_REG_J_ADDR, 32'h2);
        write_reg(`ISING_REG_J_DATA, $random(seed));
        write_reg(`ISING_REG_J_ADDR, 32'h5);
        write_reg(`ISING_REG_J_DATA, $random(seed));
        run_and_check(spins);
        finish_test("test 4 dropped J writes");

        // Fresh spins change the results if the start is taken
        write_reg(`ISING_REG_SPIN, $random(seed));
        write_reg(`ISING_REG_CTRL, 32'h5);
        repeat (12) check_reg(`ISING_REG_STATUS, 32'h3);
        check_reg(`ISING_REG_ENERGY, ising_pkg::reg_data_t'(exp_energy));
        check_reg(`ISING_REG_UNSTABLE, ising_pkg::reg_data_t'(exp_unstable));
        write_reg(`ISING_REG_CTRL, 32'h0);
        finish_test("test 5 start in load mode");

        write_reg(`ISING_REG_CTRL, 32'h2);
        // One cycle for the result latch to see the flush level
        @(posedge clk);
        #1;
        check_reg(`ISING_REG_STATUS, 32'h1);
        check_reg(`ISING_REG_ENERGY, 32'h0);
        check_reg(`ISING_REG_UNSTABLE, 32'h0);
        write_reg(`ISING_REG_CTRL, 32'h0);
        spins = ising_pkg::spin_vec_t'($random(seed));
        run_and_check(spins);
        finish_test("test 6 flush");

        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- include/ising_cfg.svh
/* Sizes and register map of the Ising core.
   Included by the package and by every module that decodes or sizes the bus. */
`ifndef ISING_CFG_SVH
`define ISING_CFG_SVH

`define ISING_NUM_SPIN   8
`define ISING_BIT_J      4
`define ISING_DATA_W     32
`define ISING_ADDR_W     3
`define ISING_ENERGY_W   16

// Host register map
`define ISING_REG_CTRL      3'd0
`define ISING_REG_SPIN      3'd1
`define ISING_REG_J_ADDR    3'd2
`define ISING_REG_J_DATA    3'd3
`define ISING_REG_STATUS    3'd4
`define ISING_REG_ENERGY    3'd5
`define ISING_REG_UNSTABLE  3'd6
`endif

//--- ising_core.f
+incdir+include
rtl/ising_pkg.sv
rtl/ising_reg_file.sv
rtl/ising_j_mem.sv
rtl/ising_energy_engine.sv
rtl/ising_result_latch.sv
rtl/ising_core_top.sv
bench/tb_clock_gen.sv
bench/tb_ising_core.sv

//--- rtl/ising_core_top.sv
/* Top of the Ising core. Connects the register block, coupling memory,
   energy engine and result registers behind a plain host register bus. */
`timescale 1ns/1ps
`default_nettype none

`include "ising_cfg.svh"

module ising_core_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [`ISING_ADDR_W-1:0] reg_addr_i,
    input  ising_pkg::reg_data_t     reg_wdata_i,
    input  logic                     reg_we_i,
    output ising_pkg::reg_data_t     reg_rdata_o
);

    logic                 start, flush, load_mode, j_wr;
    ising_pkg::spin_vec_t spin_init;
    ising_pkg::row_addr_t j_waddr, rd_addr;
    ising_pkg::j_row_t    j_wdata, rd_data;
    logic                 rd_en, idle, valid;
    ising_pkg::energy_t   eng_energy, res_energy;
    ising_pkg::count_t    eng_unstable, res_unstable;

    //////////////////////////////////////////////////////////////////////
    // Host side
    ising_reg_file i_reg_file (
        .clk_i       (clk_i       ),
        .rst_n_i     (rst_n_i     ),
        .reg_addr_i  (reg_addr_i  ),
        .reg_wdata_i (reg_wdata_i ),
        .reg_we_i    (reg_we_i    ),
        .reg_rdata_o (reg_rdata_o ),
        .idle_i      (idle        ),
        .valid_i     (valid       ),
        .energy_i    (res_energy  ),
        .unstable_i  (res_unstable),
        .start_o     (start       ),
        .flush_o     (flush       ),
        .load_mode_o (load_mode   ),
        .spin_init_o (spin_init   ),
        .j_waddr_o   (j_waddr     ),
        .j_wdata_o   (j_wdata     ),
        .j_wr_o      (j_wr        )
    );

    ising_j_mem i_j_mem (
        .clk_i       (clk_i    ),
        .rst_n_i     (rst_n_i  ),
        .load_mode_i (load_mode),
        .wr_i        (j_wr     ),
        .waddr_i     (j_waddr  ),
        .wdata_i     (j_wdata  ),
        .rd_en_i     (rd_en    ),
        .rd_addr_i   (rd_addr  ),
        .rd_data_o   (rd_data  )
    );

    //////////////////////////////////////////////////////////////////////
    // Compute and results
    ising_energy_engine i_energy_engine (
        .clk_i      (clk_i       ),
        .rst_n_i    (rst_n_i     ),
        .start_i    (start       ),
        .spin_i     (spin_init   ),
        .rd_data_i  (rd_data     ),
        .rd_en_o    (rd_en       ),
        .rd_addr_o  (rd_addr     ),
        .idle_o     (idle        ),
        .energy_o   (eng_energy  ),
        .unstable_o (eng_unstable)
    );

    ising_result_latch i_result_latch (
        .clk_i      (clk_i       ),
        .rst_n_i    (rst_n_i     ),
        .idle_i     (idle        ),
        .flush_i    (flush       ),
        .energy_i   (eng_energy  ),
        .unstable_i (eng_unstable),
        .valid_o    (valid       ),
        .energy_o   (res_energy  ),
        .unstable_o (res_unstable)
    );

endmodule

`default_nettype wire

//--- rtl/ising_energy_engine.sv
/* Energy engine. On start it streams the J rows out of memory and accumulates
   the Ising energy and the number of unstable spins, one row per cycle. */
`timescale 1ns/1ps
`default_nettype none

`include "ising_cfg.svh"

module ising_energy_engine (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  ising_pkg::spin_vec_t spin_i,
    input  ising_pkg::j_row_t    rd_data_i,
    output logic                 rd_en_o,
    output ising_pkg::row_addr_t rd_addr_o,
    output logic                 idle_o,
    output ising_pkg::energy_t   energy_o,
    output ising_pkg::count_t    unstable_o
);

    // Wide enough for NUM_SPIN terms of a signed BIT_J coupling
    localparam int FIELD_W = `ISING_BIT_J + $clog2(`ISING_NUM_SPIN) + 1;
    localparam ising_pkg::row_addr_t LAST_ROW = ising_pkg::row_addr_t'(`ISING_NUM_SPIN - 1);

    logic                 busy_q;
    logic                 rd_en_q;
    ising_pkg::row_addr_t rd_addr_q;
    logic                 data_vld_q;
    ising_pkg::row_addr_t data_row_q;
    ising_pkg::spin_vec_t spin_q;
    ising_pkg::energy_t   energy_q;
    ising_pkg::count_t    unstable_q;

    logic signed [FIELD_W-1:0] field;
    logic                      row_spin;
    logic                      row_unstable;

    //////////////////////////////////////////////////////////////////////
    // Local field of the row in the data stage
    always_comb begin
        logic signed [`ISING_BIT_J-1:0] coup;
        coup  = '0;
        field = '0;
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            coup = rd_data_i[j*`ISING_BIT_J +: `ISING_BIT_J];
            if (spin_q[j]) begin
                field = field + coup;
            end else begin
                field = field - coup;
            end
        end
    end

    assign row_spin = spin_q[data_row_q];
    // s_i * field below zero
    assign row_unstable = row_spin ? field[FIELD_W-1]
                                   : (!field[FIELD_W-1] && (field != '0));

    //////////////////////////////////////////////////////////////////////
    // Row sequencer and accumulators
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            rd_en_q    <= 1'b0;
            rd_addr_q  <= '0;
            data_vld_q <= 1'b0;
            data_row_q <= '0;
            energy_q   <= '0;
            unstable_q <= '0;
        end else if (!busy_q) begin
            data_vld_q <= 1'b0;
            if (start_i) begin
                busy_q     <= 1'b1;
                rd_en_q    <= 1'b1;
                rd_addr_q  <= '0;
                energy_q   <= '0;
                unstable_q <= '0;
            end
        end else begin
            // Address stage
            if (rd_en_q) begin
                if (rd_addr_q == LAST_ROW) begin
                    rd_en_q <= 1'b0;
                end else begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                end
            end
            data_vld_q <= rd_en_q;
            data_row_q <= rd_addr_q;
            // Data stage
            if (data_vld_q) begin
                if (row_spin) begin
                    energy_q <= energy_q - field;
                end else begin
                    energy_q <= energy_q + field;
                end
                if (row_unstable) begin
                    unstable_q <= unstable_q + 1'b1;
                end
                if (data_row_q == LAST_ROW) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i && !busy_q) begin
            spin_q <= spin_i;
        end
    end

    assign rd_en_o    = rd_en_q;
    assign rd_addr_o  = rd_addr_q;
    assign idle_o     = ~busy_q;
    assign energy_o   = energy_q;
    assign unstable_o = unstable_q;

    a_no_read_when_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rd_en_o |-> !idle_o
    );

    // Row counter stops at the last row and never wraps
    a_row_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rd_en_o && rd_addr_o == LAST_ROW) |=> !rd_en_o
    );

endmodule

`default_nettype wire

//--- rtl/ising_j_mem.sv
/* Coupling memory, one J row per word. Host writes pass only in load mode,
   the engine reads with one cycle of latency. */
`timescale 1ns/1ps
`default_nettype none

`include "ising_cfg.svh"

module ising_j_mem (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 load_mode_i,
    input  logic                 wr_i,
    input  ising_pkg::row_addr_t waddr_i,
    input  ising_pkg::j_row_t    wdata_i,
    input  logic                 rd_en_i,
    input  ising_pkg::row_addr_t rd_addr_i,
    output ising_pkg::j_row_t    rd_data_o
);

    ising_pkg::j_row_t [`ISING_NUM_SPIN-1:0] mem_q;
    ising_pkg::j_row_t                       rd_data_q;
    logic                                    mem_we;

    // Load port only reaches the array in load mode
    assign mem_we = wr_i & load_mode_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_q <= '0;
        end else if (mem_we) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // Compute port
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_q <= mem_q[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

    a_no_write_outside_load: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !load_mode_i |=> $stable(mem_q)
    );

endmodule

`default_nettype wire

//--- rtl/ising_pkg.sv
/* Shared data types of the Ising core, sized from the configuration header. */
`default_nettype none

`include "ising_cfg.svh"

package ising_pkg;

    // One bit per spin, 1 means +1 and 0 means -1
    typedef logic [`ISING_NUM_SPIN-1:0] spin_vec_t;

    // Coupling j of a row sits in bits BIT_J*j upward
    typedef logic [`ISING_NUM_SPIN*`ISING_BIT_J-1:0] j_row_t;

    typedef logic [$clog2(`ISING_NUM_SPIN)-1:0] row_addr_t;
    typedef logic signed [`ISING_ENERGY_W-1:0] energy_t;

    // Needs one extra bit, all spins may be unstable
    typedef logic [$clog2(`ISING_NUM_SPIN):0] count_t;

    typedef logic [`ISING_DATA_W-1:0] reg_data_t;

endpackage

`default_nettype wire

//--- rtl/ising_reg_file.sv
/* Host register block. Turns bus writes into control levels, start and J write
   pulses, and serves combinational readback of status and results. */
`timescale 1ns/1ps
`default_nettype none

`include "ising_cfg.svh"

module ising_reg_file (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [`ISING_ADDR_W-1:0] reg_addr_i,
    input  ising_pkg::reg_data_t     reg_wdata_i,
    input  logic                     reg_we_i,
    output ising_pkg::reg_data_t     reg_rdata_o,
    input  logic                     idle_i,
    input  logic                     valid_i,
    input  ising_pkg::energy_t       energy_i,
    input  ising_pkg::count_t        unstable_i,
    output logic                     start_o,
    output logic                     flush_o,
    output logic                     load_mode_o,
    output ising_pkg::spin_vec_t     spin_init_o,
    output ising_pkg::row_addr_t     j_waddr_o,
    output ising_pkg::j_row_t        j_wdata_o,
    output logic                     j_wr_o
);

    logic                 wr_ctrl, wr_spin, wr_jaddr, wr_jdata;
    logic                 start_q, flush_q, load_mode_q, j_wr_q;
    ising_pkg::spin_vec_t spin_q;
    ising_pkg::row_addr_t j_addr_q;
    ising_pkg::j_row_t    j_wdata_q;

    assign wr_ctrl  = reg_we_i && (reg_addr_i == `ISING_REG_CTRL);
    assign wr_spin  = reg_we_i && (reg_addr_i == `ISING_REG_SPIN);
    assign wr_jaddr = reg_we_i && (reg_addr_i == `ISING_REG_J_ADDR);
    assign wr_jdata = reg_we_i && (reg_addr_i == `ISING_REG_J_DATA);

    //////////////////////////////////////////////////////////////////////
    // Write side
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_q     <= 1'b0;
            flush_q     <= 1'b0;
            load_mode_q <= 1'b0;
            j_wr_q      <= 1'b0;
            spin_q      <= '0;
            j_addr_q    <= '0;
        end else begin
            // Start bit is never stored, and is refused in load mode
            start_q <= wr_ctrl & reg_wdata_i[0] & ~reg_wdata_i[2];
            j_wr_q  <= wr_jdata;
            if (wr_ctrl) begin
                flush_q     <= reg_wdata_i[1];
                load_mode_q <= reg_wdata_i[2];
            end
            if (wr_spin) begin
                spin_q <= reg_wdata_i[`ISING_NUM_SPIN-1:0];
            end
            if (wr_jaddr) begin
                j_addr_q <= reg_wdata_i[$bits(ising_pkg::row_addr_t)-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_jdata) begin
            j_wdata_q <= reg_wdata_i;
        end
    end

    assign start_o     = start_q;
    assign flush_o     = flush_q;
    assign load_mode_o = load_mode_q;
    assign spin_init_o = spin_q;
    assign j_waddr_o   = j_addr_q;
    assign j_wdata_o   = j_wdata_q;
    assign j_wr_o      = j_wr_q;

    //////////////////////////////////////////////////////////////////////
    // Readback
    always_comb begin
        reg_rdata_o = '0;
        case (reg_addr_i)
            `ISING_REG_CTRL: begin
                reg_rdata_o[1] = flush_q;
                reg_rdata_o[2] = load_mode_q;
            end
            `ISING_REG_SPIN:   reg_rdata_o[`ISING_NUM_SPIN-1:0] = spin_q;
            `ISING_REG_J_ADDR: reg_rdata_o[$bits(ising_pkg::row_addr_t)-1:0] = j_addr_q;
            `ISING_REG_STATUS: begin
                reg_rdata_o[0] = idle_i;
                reg_rdata_o[1] = valid_i;
            end
            `ISING_REG_ENERGY: begin
                reg_rdata_o = {{(`ISING_DATA_W-`ISING_ENERGY_W){energy_i[`ISING_ENERGY_W-1]}},
                               energy_i};
            end
            `ISING_REG_UNSTABLE: reg_rdata_o[$bits(ising_pkg::count_t)-1:0] = unstable_i;
            default: reg_rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ising_result_latch.sv
/* Result readback registers, loaded when the engine goes back to idle
   and cleared by flush. */
`timescale 1ns/1ps
`default_nettype none

module ising_result_latch (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               idle_i,
    input  logic               flush_i,
    input  ising_pkg::energy_t energy_i,
    input  ising_pkg::count_t  unstable_i,
    output logic               valid_o,
    output ising_pkg::energy_t energy_o,
    output ising_pkg::count_t  unstable_o
);

    logic               idle_d_q;
    logic               idle_rise;
    logic               valid_q;
    ising_pkg::energy_t energy_q;
    ising_pkg::count_t  unstable_q;

    assign idle_rise = idle_i & ~idle_d_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            idle_d_q   <= 1'b1;
            valid_q    <= 1'b0;
            energy_q   <= '0;
            unstable_q <= '0;
        end else begin
            idle_d_q <= idle_i;
            // Flush wins over a capture in the same cycle
            if (flush_i) begin
                valid_q    <= 1'b0;
                energy_q   <= '0;
                unstable_q <= '0;
            end else if (idle_rise) begin
                valid_q    <= 1'b1;
                energy_q   <= energy_i;
                unstable_q <= unstable_i;
            end
        end
    end

    assign valid_o    = valid_q;
    assign energy_o   = energy_q;
    assign unstable_o = unstable_q;

    a_flush_clears_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !valid_o
    );

endmodule

`default_nettype wire
